//--- common/sld_pkg.sv
/*
  Shared widths, types and structs of the vector slide unit.
  Referenced by scoped names from the RTL and the testbench.
*/
package sld_pkg;

    ////////////////////
    // widths and counts

    localparam int VREG_W   = 128;
    localparam int SLD_OP_W = 32;
    localparam int VREG_B   = VREG_W / 8;
    localparam int OP_B     = SLD_OP_W / 8;
    localparam int CHUNKS   = VREG_W / SLD_OP_W;
    localparam int SHIFT_W  = 5;
    localparam int VL_W     = 5;
    // byte offset bits inside one chunk
    localparam int OP_SH    = $clog2(OP_B);

    ////////////////////
    // plain vectors

    typedef logic [VREG_W-1:0]   vreg_t;
    typedef logic [VREG_B-1:0]   vmask_t;
    typedef logic [SLD_OP_W-1:0] chunk_t;
    typedef logic [OP_B-1:0]     chunk_mask_t;
    typedef logic [4:0]          vaddr_t;
    typedef logic [2:0]          chunk_idx_t;
    typedef logic [SHIFT_W-1:0]  byte_shift_t;

    ////////////////////
    // enums

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_dir_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        READ   = 2'd1,
        STREAM = 2'd2
    } sld_fsm_e;

    ////////////////////
    // structs

    // operation as issued, rs1 and vl count elements
    typedef struct packed {
        sld_dir_e         dir;
        sew_e             sew;
        logic [31:0]      rs1;
        logic [VL_W-1:0]  vl;
        vaddr_t           vs2;
        vaddr_t           vd;
    } sld_op_t;

    // decoded control, held for one whole operation
    typedef struct packed {
        sld_dir_e    dir;
        byte_shift_t byte_shift;
        logic        overflow;
        byte_shift_t vl_bytes;
        vaddr_t      vd;
    } sld_ctrl_t;

    typedef struct packed {
        logic        valid;
        logic        last;
        chunk_idx_t  idx;
        chunk_t      data;
        chunk_mask_t bvalid;
    } chunk_tok_t;

    typedef struct packed {
        logic   en;
        vaddr_t addr;
        vreg_t  data;
        vmask_t mask;
    } vreg_wr_t;

endpackage

//--- slide/sld_decode.sv
/*
  Operation decode and chunk sequencer of the slide unit.
  Converts the element counts to bytes, then reads the source and streams four chunks.
*/
module sld_decode (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 op_valid_i,
    input  sld_pkg::sld_op_t     op_i,
    input  logic                 done_i,
    output logic                 busy_o,

    output sld_pkg::sld_ctrl_t   ctrl_o,
    output sld_pkg::vaddr_t      vreg_rd_addr_o,
    output logic                 load_o,
    output logic                 chunk_go_o,
    output sld_pkg::chunk_idx_t  chunk_idx_o
);

    sld_pkg::sld_fsm_e   state_q, state_d;
    sld_pkg::sld_ctrl_t  ctrl_q, ctrl_d;
    sld_pkg::vaddr_t     rd_addr_q;
    sld_pkg::chunk_idx_t idx_q;
    logic                go_q;
    logic                accept;
    logic [1:0]          esh;
    logic [33:0]         shift_full;
    logic [6:0]          vl_full;

    assign accept = op_valid_i && (state_q == sld_pkg::IDLE);

    ////////////////////
    // operation decode

    // log2 of the element size in bytes
    always_comb begin
        case (op_i.sew)
            sld_pkg::SEW_16: esh = 2'd1;
            sld_pkg::SEW_32: esh = 2'd2;
            default:         esh = 2'd0;
        endcase
    end

    assign shift_full = {2'b00, op_i.rs1} << esh;
    assign vl_full    = {2'b00, op_i.vl} << esh;

    always_comb begin
        ctrl_d          = '0;
        ctrl_d.dir      = op_i.dir;
        ctrl_d.vd       = op_i.vd;
        // slide of a whole register or more
        ctrl_d.overflow = shift_full[33:$clog2(sld_pkg::VREG_B)] != '0;
        if (!ctrl_d.overflow) begin
            ctrl_d.byte_shift = shift_full[sld_pkg::SHIFT_W-1:0];
        end
        if (vl_full > 7'(sld_pkg::VREG_B)) begin
            ctrl_d.vl_bytes = sld_pkg::byte_shift_t'(sld_pkg::VREG_B);
        end else begin
            ctrl_d.vl_bytes = vl_full[sld_pkg::SHIFT_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ctrl_q    <= ctrl_d;
            rd_addr_q <= op_i.vs2;
        end
    end

    ////////////////////
    // chunk sequencer

    always_comb begin
        state_d = state_q;
        case (state_q)
            sld_pkg::IDLE:   if (op_valid_i) state_d = sld_pkg::READ;
            sld_pkg::READ:   state_d = sld_pkg::STREAM;
            // hold busy until the write goes out
            sld_pkg::STREAM: if (done_i) state_d = sld_pkg::IDLE;
            default:         state_d = sld_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= sld_pkg::IDLE;
            idx_q   <= '0;
            go_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == sld_pkg::READ) begin
                idx_q <= '0;
                go_q  <= 1'b1;
            end else if (go_q) begin
                if (idx_q == sld_pkg::chunk_idx_t'(sld_pkg::CHUNKS - 1)) begin
                    go_q <= 1'b0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    assign busy_o         = state_q != sld_pkg::IDLE;
    assign load_o         = state_q == sld_pkg::READ;
    assign chunk_go_o     = go_q;
    assign chunk_idx_o    = idx_q;
    assign ctrl_o         = ctrl_q;
    assign vreg_rd_addr_o = rd_addr_q;

    // issuer must wait for busy to drop
    assert property (@(posedge clk_i) disable iff (!rst_ni) busy_o |-> !op_valid_i);

    // the last chunk is followed by no further chunk strobe
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        chunk_go_o |-> (chunk_idx_o <= sld_pkg::chunk_idx_t'(sld_pkg::CHUNKS - 1)) ##1
        (!chunk_go_o || chunk_idx_o != '0));

endmodule

//--- slide/sld_execute.sv
/*
  Slide datapath: holds the source register and builds one slid chunk per cycle.
  Each output token carries byte valid flags for the slide-up and overflow rules.
*/
module sld_execute (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 load_i,
    input  logic                 chunk_go_i,
    input  sld_pkg::chunk_idx_t  chunk_idx_i,
    input  sld_pkg::sld_ctrl_t   ctrl_i,
    input  sld_pkg::vreg_t       vreg_rd_i,

    output sld_pkg::chunk_tok_t  tok_o
);

    sld_pkg::vreg_t               src_q;
    sld_pkg::chunk_t              lo_chunk;
    sld_pkg::chunk_t              hi_chunk;
    sld_pkg::chunk_t              data_d, data_q;
    sld_pkg::chunk_mask_t         bvalid_d, bvalid_q;
    sld_pkg::chunk_idx_t          idx_q;
    logic [2*sld_pkg::SLD_OP_W-1:0] pair;
    logic                         valid_q;
    logic                         last_q;
    int                           q_chunks;
    int                           r_bytes;
    int                           lo_idx;
    int                           sh_bytes;
    int                           base;

    // source chunk, zero outside the register
    function automatic sld_pkg::chunk_t pick_chunk(input sld_pkg::vreg_t src, input int idx);
        sld_pkg::chunk_t c;
        c = '0;
        if (idx >= 0 && idx < sld_pkg::CHUNKS) begin
            c = src[idx*sld_pkg::SLD_OP_W +: sld_pkg::SLD_OP_W];
        end
        return c;
    endfunction

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            src_q <= vreg_rd_i;
        end
    end

    ////////////////////
    // chunk select and byte shift

    always_comb begin
        q_chunks = int'(ctrl_i.byte_shift[sld_pkg::SHIFT_W-1:sld_pkg::OP_SH]);
        r_bytes  = int'(ctrl_i.byte_shift[sld_pkg::OP_SH-1:0]);
        base     = int'(chunk_idx_i) * sld_pkg::OP_B;

        // the pair spans both chunks that feed this output chunk
        if (ctrl_i.dir == sld_pkg::SLD_UP) begin
            lo_idx   = int'(chunk_idx_i) - q_chunks - 1;
            sh_bytes = sld_pkg::OP_B - r_bytes;
        end else begin
            lo_idx   = int'(chunk_idx_i) + q_chunks;
            sh_bytes = r_bytes;
        end

        lo_chunk = pick_chunk(src_q, lo_idx);
        hi_chunk = pick_chunk(src_q, lo_idx + 1);
        pair     = {hi_chunk, lo_chunk};
        data_d   = sld_pkg::chunk_t'(pair >> (8 * sh_bytes));

        for (int j = 0; j < sld_pkg::OP_B; j++) begin
            if (ctrl_i.dir == sld_pkg::SLD_UP) begin
                bvalid_d[j] = (base + j) >= int'(ctrl_i.byte_shift);
            end else begin
                bvalid_d[j] = 1'b1;
            end
        end

        // oversized slide: nothing moves up, zeros come down
        if (ctrl_i.overflow) begin
            if (ctrl_i.dir == sld_pkg::SLD_UP) begin
                bvalid_d = '0;
            end else begin
                data_d = '0;
            end
        end
    end

    ////////////////////
    // output token

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= chunk_go_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (chunk_go_i) begin
            data_q   <= data_d;
            bvalid_q <= bvalid_d;
            idx_q    <= chunk_idx_i;
            last_q   <= chunk_idx_i == sld_pkg::chunk_idx_t'(sld_pkg::CHUNKS - 1);
        end
    end

    assign tok_o = '{
        valid:  valid_q,
        last:   last_q,
        idx:    idx_q,
        data:   data_q,
        bvalid: bvalid_q
    };

    // source latch and streaming never overlap
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(chunk_go_i && load_i));

endmodule

//--- slide/sld_result.sv
/*
  Result stage: gathers the four chunks of one destination register.
  Applies the vl tail mask and issues a single register write per operation.
*/
module sld_result (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  sld_pkg::chunk_tok_t tok_i,
    input  sld_pkg::sld_ctrl_t  ctrl_i,

    output sld_pkg::vreg_wr_t   vreg_wr_o,
    output logic                done_o
);

    sld_pkg::vreg_t        data_q;
    sld_pkg::vmask_t       mask_q;
    sld_pkg::vmask_t       tail_mask;
    logic [sld_pkg::VREG_B:0] tail_full;
    logic                  last_q;
    logic                  wr_en_q;
    sld_pkg::vaddr_t       wr_addr_q;
    sld_pkg::vreg_t        wr_data_q;
    sld_pkg::vmask_t       wr_mask_q;

    ////////////////////
    // destination shift register

    // lowest chunk enters first and ends at the bottom
    always_ff @(posedge clk_i) begin
        if (tok_i.valid) begin
            data_q <= {tok_i.data, data_q[sld_pkg::VREG_W-1:sld_pkg::SLD_OP_W]};
            mask_q <= {tok_i.bvalid, mask_q[sld_pkg::VREG_B-1:sld_pkg::OP_B]};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= 1'b0;
        end else begin
            last_q <= tok_i.valid && tok_i.last;
        end
    end

    ////////////////////
    // tail mask and write

    // bytes below vl_bytes stay enabled
    assign tail_full = ({{sld_pkg::VREG_B{1'b0}}, 1'b1} << ctrl_i.vl_bytes) - 1'b1;
    assign tail_mask = tail_full[sld_pkg::VREG_B-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_en_q   <= 1'b0;
            wr_mask_q <= '0;
        end else begin
            wr_en_q   <= last_q;
            wr_mask_q <= last_q ? (mask_q & tail_mask) : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (last_q) begin
            wr_addr_q <= ctrl_i.vd;
            wr_data_q <= data_q;
        end
    end

    assign vreg_wr_o = '{
        en:   wr_en_q,
        addr: wr_addr_q,
        data: wr_data_q,
        mask: wr_mask_q
    };

    // write is being registered this cycle
    assign done_o = last_q;

    // idle write port carries no enabled bytes
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !vreg_wr_o.en |-> vreg_wr_o.mask == '0);

endmodule

//--- hdl/sld_unit.sv
/*
  Top level of the vector slide unit: decode, execute and result stages.
  The register file sits outside and is reached through the read and write ports.
*/
module sld_unit (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                op_valid_i,
    input  sld_pkg::sld_op_t    op_i,
    output logic                busy_o,

    // register file ports
    output sld_pkg::vaddr_t     vreg_rd_addr_o,
    input  sld_pkg::vreg_t      vreg_rd_i,
    output sld_pkg::vreg_wr_t   vreg_wr_o
);

    sld_pkg::sld_ctrl_t  ctrl;
    sld_pkg::chunk_idx_t chunk_idx;
    sld_pkg::chunk_tok_t tok;
    logic                load;
    logic                chunk_go;
    logic                done;

    sld_decode u_decode (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .done_i         (done),
        .busy_o         (busy_o),
        .ctrl_o         (ctrl),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .load_o         (load),
        .chunk_go_o     (chunk_go),
        .chunk_idx_o    (chunk_idx)
    );

    sld_execute u_execute (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (load),
        .chunk_go_i  (chunk_go),
        .chunk_idx_i (chunk_idx),
        .ctrl_i      (ctrl),
        .vreg_rd_i   (vreg_rd_i),
        .tok_o       (tok)
    );

    sld_result u_result (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .tok_i     (tok),
        .ctrl_i    (ctrl),
        .vreg_wr_o (vreg_wr_o),
        .done_o    (done)
    );

endmodule

//--- verification/tb_sld.sv
/*
  Testbench of the vector slide unit, driven by the test table in the input data file.
  Models the register file read side, checks every register write and prints a summary.
*/
module tb_sld;

    localparam int    CLK_PERIOD = 8;
    // edges from the accepting edge to the registered write
    localparam int    WR_EDGES   = 7;
    localparam int    WAIT_MAX   = 20;
    localparam string INPUT_FILE = "verification/sld_input.txt";

    logic                clk;
    logic                rst_n;
    logic                op_valid;
    sld_pkg::sld_op_t    op;
    logic                busy;
    sld_pkg::vaddr_t     rd_addr;
    sld_pkg::vreg_t      rd_data;
    sld_pkg::vreg_wr_t   wr;

    // read side of the register file model
    sld_pkg::vreg_t      regs [32];

    // test table
    string               name_q [$];
    sld_pkg::sld_op_t    op_q [$];
    sld_pkg::vreg_t      src_q [$];
    sld_pkg::vreg_t      exp_data_q [$];
    sld_pkg::vmask_t     exp_mask_q [$];

    int                  num_tests;
    logic                tests_ready;
    int                  check_fails;
    int                  tests_failed;

    sld_unit uut (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .op_valid_i     (op_valid),
        .op_i           (op),
        .busy_o         (busy),
        .vreg_rd_addr_o (rd_addr),
        .vreg_rd_i      (rd_data),
        .vreg_wr_o      (wr)
    );

    assign rd_data = regs[rd_addr];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // helpers

    function automatic sld_pkg::vreg_t expand_byte_mask(input sld_pkg::vmask_t m);
        sld_pkg::vreg_t bits;
        bits = '0;
        for (int i = 0; i < sld_pkg::VREG_B; i++) begin
            bits[8*i +: 8] = {8{m[i]}};
        end
        return bits;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [127:0] exp, input logic [127:0] act);
        $display("Mismatch in %s, %s: expected %0h, actual %0h", test, what, exp, act);
        check_fails++;
    endtask

    task automatic report_failure(input string text);
        $display("%s", text);
        check_fails++;
    endtask

    ////////////////////
    // test table from file

    task automatic load_tests();
        int               fd;
        int               n;
        int               line_no;
        string            line;
        string            name;
        string            dir_s;
        int               sew_n;
        logic [31:0]      rs1;
        int               vl_n;
        int               vs2_n;
        int               vd_n;
        sld_pkg::vreg_t   src;
        sld_pkg::vreg_t   exp_data;
        sld_pkg::vmask_t  exp_mask;
        sld_pkg::sld_op_t o;
        logic             line_ok;

        line_no = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            report_failure($sformatf("cannot open the input file %s", INPUT_FILE));
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                // comment lines
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %s %d %h %d %d %d %h %h %h", name, dir_s, sew_n,
                            rs1, vl_n, vs2_n, vd_n, src, exp_data, exp_mask);
                if (n <= 0) begin
                    continue;
                end
                line_ok = 1'b1;
                o       = '0;
                if (n != 10) begin
                    report_failure($sformatf("line %0d of the input file is malformed", line_no));
                    line_ok = 1'b0;
                end
                if (dir_s == "down") begin
                    o.dir = sld_pkg::SLD_DOWN;
                end else if (dir_s == "up") begin
                    o.dir = sld_pkg::SLD_UP;
                end else begin
                    report_failure($sformatf("line %0d has an unknown direction", line_no));
                    line_ok = 1'b0;
                end
                case (sew_n)
                    8:       o.sew = sld_pkg::SEW_8;
                    16:      o.sew = sld_pkg::SEW_16;
                    32:      o.sew = sld_pkg::SEW_32;
                    default: begin
                        report_failure($sformatf("line %0d has an unknown sew", line_no));
                        line_ok = 1'b0;
                    end
                endcase
                o.rs1 = rs1;
                o.vl  = vl_n[sld_pkg::VL_W-1:0];
                o.vs2 = vs2_n[4:0];
                o.vd  = vd_n[4:0];
                if (line_ok) begin
                    name_q.push_back(name);
                    op_q.push_back(o);
                    src_q.push_back(src);
                    exp_data_q.push_back(exp_data);
                    exp_mask_q.push_back(exp_mask);
                end
            end
            $fclose(fd);
            if (name_q.size() == 0) begin
                report_failure("the input file holds no tests");
            end
        end
    endtask

    ////////////////////
    // one operation

    task automatic run_test(input int t);
        sld_pkg::sld_op_t o;
        sld_pkg::vreg_t   keep;
        int               edges;
        int               fails_before;
        string            name;

        o            = op_q[t];
        name         = name_q[t];
        fails_before = check_fails;
        keep         = expand_byte_mask(exp_mask_q[t]);

        assert (!busy) else
            report_failure($sformatf("busy_o was still high when %s was issued", name));

        regs[o.vs2] = src_q[t];
        op          = o;
        op_valid    = 1'b1;
        @(negedge clk);
        op_valid = 1'b0;
        edges    = 0;
        assert (busy) else report_mismatch(name, "busy_o after accept", 1, busy);
        assert (rd_addr == o.vs2) else
            report_mismatch(name, "read address", o.vs2, rd_addr);

        while (!wr.en && edges < WAIT_MAX) begin
            @(negedge clk);
            edges++;
        end

        if (!wr.en) begin
            report_failure($sformatf("no register write for %s within %0d cycles",
                                     name, WAIT_MAX));
        end else begin
            assert (edges == WR_EDGES) else
                report_mismatch(name, "write latency in edges", WR_EDGES, edges);
            assert (wr.addr == o.vd) else
                report_mismatch(name, "write address", o.vd, wr.addr);
            assert (wr.mask == exp_mask_q[t]) else
                report_mismatch(name, "write mask", exp_mask_q[t], wr.mask);
            assert ((wr.data & keep) == (exp_data_q[t] & keep)) else
                report_mismatch(name, "enabled write data", exp_data_q[t] & keep,
                                wr.data & keep);
            assert (!busy) else report_mismatch(name, "busy_o after write", 0, busy);
        end

        if (check_fails == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED", name);
            tests_failed++;
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        rst_n        = 1'b0;
        op_valid     = 1'b0;
        op           = '0;
        check_fails  = 0;
        tests_failed = 0;
        num_tests    = 0;
        tests_ready  = 1'b0;
        for (int a = 0; a < 32; a++) begin
            regs[a] = {16{8'(a) ^ 8'h3c}};
        end

        load_tests();
        num_tests   = name_q.size();
        tests_ready = 1'b1;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // tests go back to back as soon as busy_o drops
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        @(negedge clk);
        assert (!wr.en) else report_failure("write enable stayed high after the last write");

        $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
                 num_tests, num_tests - tests_failed, tests_failed, check_fails);
        if (check_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog allows about 20 cycles per test plus reset and margin
    initial begin
        wait (tests_ready);
        #((num_tests * 20 + 100) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", num_tests * 20 + 100);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- verification/sld_input.txt
# name dir sew rs1(hex) vl(dec) vs2 vd source(hex) expected_data(hex) expected_mask(hex)
# sew in bits, rs1 and vl in elements, data in disabled bytes is not compared
#
# slide-up, full vl
up_e8_k0     up   8  0        16  1  2  0f0e0d0c0b0a09080706050403020100 0f0e0d0c0b0a09080706050403020100 ffff
up_e8_k3     up   8  3        16  3  4  0f0e0d0c0b0a09080706050403020100 0c0b0a09080706050403020100000000 fff8
up_e8_k5     up   8  5        16  5  6  afaeadacabaaa9a8a7a6a5a4a3a2a1a0 aaa9a8a7a6a5a4a3a2a1a00000000000 ffe0
up_e16_r2    up   16 2        8   7  8  0f0e0d0c0b0a09080706050403020100 0b0a0908070605040302010000000000 fff0
up_e32_r1    up   32 1        4   9  10 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 abaaa9a8a7a6a5a4a3a2a1a000000000 fff0
up_e32_r3    up   32 3        4   11 12 0f0e0d0c0b0a09080706050403020100 03020100000000000000000000000000 f000
up_e16_r7    up   16 7        8   13 14 5f5e5d5c5b5a59585756555453525150 51500000000000000000000000000000 c000
#
# slide-down, full vl
dn_e8_k0     down 8  0        16  15 16 0f0e0d0c0b0a09080706050403020100 0f0e0d0c0b0a09080706050403020100 ffff
dn_e8_k3     down 8  3        16  17 18 0f0e0d0c0b0a09080706050403020100 0000000f0e0d0c0b0a09080706050403 ffff
dn_e8_k6     down 8  6        16  19 20 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 000000000000afaeadacabaaa9a8a7a6 ffff
dn_e16_r3    down 16 3        8   21 22 5f5e5d5c5b5a59585756555453525150 0000000000005f5e5d5c5b5a59585756 ffff
dn_e32_r1    down 32 1        4   23 24 0f0e0d0c0b0a09080706050403020100 000000000f0e0d0c0b0a090807060504 ffff
dn_e32_r2    down 32 2        4   25 26 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0000000000000000afaeadacabaaa9a8 ffff
dn_e16_r5    down 16 5        8   27 28 0f0e0d0c0b0a09080706050403020100 000000000000000000000f0e0d0c0b0a ffff
#
# oversized slide amounts
ovf_up_e8    up   8  10       16  29 30 0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000 0000
ovf_up_e32   up   32 3e8      4   31 0  afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00000000000000000000000000000000 0000
ovf_dn_e16   down 16 8        8   0  1  0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000 ffff
ovf_dn_max   down 8  ffffffff 16  2  3  5f5e5d5c5b5a59585756555453525150 00000000000000000000000000000000 ffff
#
# tail protection below vlmax
tail_up_e8   up   8  2        10  4  5  0f0e0d0c0b0a09080706050403020100 00000000000007060504030201000000 03fc
tail_dn_e8   down 8  4        5   6  7  afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0000000000000000000000a8a7a6a5a4 001f
tail_up_e16  up   16 1        5   8  9  5f5e5d5c5b5a59585756555453525150 00000000000057565554535251500000 03fc
tail_dn_e32  down 32 1        3   10 11 0f0e0d0c0b0a09080706050403020100 000000000f0e0d0c0b0a090807060504 0fff
tail_up_vl0  up   8  0        0   12 13 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00000000000000000000000000000000 0000
tail_dn_ovf  down 8  14       6   14 15 5f5e5d5c5b5a59585756555453525150 00000000000000000000000000000000 003f
tail_up_past up   8  8        6   16 17 0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000 0000
vl_clamp     down 32 0        31  18 19 5f5e5d5c5b5a59585756555453525150 5f5e5d5c5b5a59585756555453525150 ffff

//--- tb.f
common/sld_pkg.sv
slide/sld_decode.sv
slide/sld_execute.sv
slide/sld_result.sv
hdl/sld_unit.sv
verification/tb_sld.sv

//--- Makefile
# Verilator simulation of the vector slide unit

SRCS := $(shell cat tb.f)

all: run

obj_dir/Vtb_sld: tb.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_sld -f tb.f

run: obj_dir/Vtb_sld
	./obj_dir/Vtb_sld > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" sim.log; then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
